/* run.sh */
#!/bin/sh
# Build the heap testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module heapTb -f sources.f || exit 1
output=$(./obj_dir/VheapTb)
echo "$output"
echo "$output" | grep -q "TB PASSED" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* sim/heapModel.svh */
//----------------------------
// Reference model of the heap, included into the testbench body.
// applyModel predicts the error code and response word of a request.
//----------------------------
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

logic [`HEAP_DATA_BITS-1:0]  modelMem [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
int                          modelSizes [`HEAP_ARRAYS];
bit                          modelFlags [`HEAP_ARRAYS];
logic [`HEAP_ARRAY_BITS-1:0] modelStack [`HEAP_ARRAYS];      // Freed handles, LIFO
int                          modelDepth;
int                          modelNext;                      // Next never-used handle

task automatic resetModel();
  for (int i = 0; i < `HEAP_ARRAYS; i++) begin
    modelSizes[i] = 0;
    modelFlags[i] = 1'b0;
  end
  modelDepth = 0;
  modelNext  = 0;
endtask

task automatic applyModel(input  logic [`HEAP_OP_BITS-1:0]    op,
                          input  logic [`HEAP_ARRAY_BITS-1:0] arr,
                          input  logic [`HEAP_INDEX_BITS-1:0] idx,
                          input  logic [`HEAP_DATA_BITS-1:0]  data,
                          output heapErr_t                    err,
                          output heapWord_t                   word);
  logic [`HEAP_DATA_BITS-1:0]  old;
  logic [`HEAP_DATA_BITS-1:0]  result;
  logic [`HEAP_ARRAY_BITS-1:0] grant;
  int                          size;
  int                          slot;
  err  = errNone;
  word = '0;
  old  = modelMem[arr][idx];
  size = modelSizes[arr];
  slot = idx;
  //----------------------------
  // Checks in order of priority
  //----------------------------
  if (!(op inside {opWrite, opRead, opSize, opPush, opPop, opAlloc, opFree,
                   opAdd, opSubtract, opOr, opXor, opAnd})) err = errBadOp;
  else if (op == opAlloc) begin
    if (modelDepth == 0 && modelNext == `HEAP_ARRAYS) err = errOutOfMemory;
  end
  else if (!modelFlags[arr]) err = errNotAllocated;
  else if (op inside {opRead, opAdd, opSubtract, opOr, opXor, opAnd} && slot >= size)
    err = errOutOfBounds;
  else if (op == opPush && size == `HEAP_ARRAY_LENGTH) err = errFull;
  else if (op == opPop && size == 0) err = errEmpty;
  if (err == errNone) begin
    case (op)
      opAlloc: begin
        if (modelDepth > 0) begin                            // Freed arrays go first
          modelDepth--;
          grant = modelStack[modelDepth];
        end else begin
          grant = modelNext[`HEAP_ARRAY_BITS-1:0];
          modelNext++;
        end
        modelFlags[grant]  = 1'b1;
        modelSizes[grant]  = 0;
        word.counted.count = grant;
      end
      opFree: begin
        modelFlags[arr]        = 1'b0;
        modelStack[modelDepth] = arr;
        modelDepth++;
      end
      opWrite: begin
        modelMem[arr][idx] = data;
        if (slot + 1 > size) modelSizes[arr] = slot + 1;
      end
      opRead:  word.element = old;
      opSize:  word.counted.count = size[`HEAP_SIZE_BITS-1:0];
      opPush: begin
        modelMem[arr][size] = data;
        modelSizes[arr]     = size + 1;
      end
      opPop: begin
        word.element    = modelMem[arr][size - 1];           // Last element out
        modelSizes[arr] = size - 1;
      end
      opAdd, opSubtract, opOr, opXor, opAnd: begin
        if (op == opAdd) result = old + data;
        else if (op == opSubtract) result = old - data;
        else if (op == opOr) result = old | data;
        else if (op == opXor) result = old ^ data;
        else result = old & data;
        modelMem[arr][idx] = result;
        word.element       = result;
      end
      default: ;
    endcase
  end
endtask

`endif

/* sim/heapTb.sv */
//----------------------------
// Testbench of the array heap. Directed phases, then random
// Wishbone requests, each checked against the included model.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module heapTb import heapPkg::*; ();

  localparam int numRandom     = 400;
  localparam int numDirected   = 220;                        // Upper bound of directed requests
  localparam int totalRequests = numRandom + numDirected;
  localparam int clockPeriod   = 10;
  localparam heapOp_t legalOps [12] = '{opWrite, opRead, opSize, opPush, opPop, opAlloc,
                                        opFree, opAdd, opSubtract, opOr, opXor, opAnd};

  logic                       clock;
  logic                       reset;
  logic                       wbCyc;
  logic                       wbStb;
  logic [`HEAP_ADR_BITS-1:0]  wbAdr;
  logic [`HEAP_DATA_BITS-1:0] wbDatW;
  heapWord_t                  wbDatR;
  logic                       wbAck;
  logic                       wbErr;
  heapErr_t                   errorCode;
  integer                     seed;
  int                         passCount;
  int                         failCount;
  int                         testStart;                     // Failures before the current test

  `include "heapModel.svh"

  heapTop u_heapTop (
    .clock     (clock),
    .reset     (reset),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbAdr     (wbAdr),
    .wbDatW    (wbDatW),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .wbErr     (wbErr),
    .errorCode (errorCode)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Each request needs well under 10 cycles
  initial begin
    #(totalRequests * 10 * clockPeriod + 1000);
    $display("Watchdog expired before all requests were answered");
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  //----------------------------
  // Compare tasks
  //----------------------------
  task automatic checkWord(input heapWord_t got, input heapWord_t exp, input logic [4:0] op);
    if (got !== exp) begin
      $display("Error at %0t ns: opcode %0d returned %h, expected %h", $time, op, got, exp);
      failCount++;
    end else passCount++;
  endtask

  task automatic checkErr(input heapErr_t got, input logic ack, input logic err,
                          input heapErr_t exp);
    if (got !== exp || err !== (exp != errNone) || ack !== (exp == errNone)) begin
      $display("Error at %0t ns: code %s with ack %b err %b, expected %s",
               $time, got.name(), ack, err, exp.name());
      failCount++;
    end else passCount++;
  endtask

  task automatic checkLatency(input int cycles);
    if (cycles != 3) begin
      $display("Response came %0d cycles after the request was accepted instead of 3", cycles);
      failCount++;
    end else passCount++;
  endtask

  //----------------------------
  // Wishbone master
  //----------------------------
  task automatic doRequest(input logic [`HEAP_OP_BITS-1:0]    op,
                           input logic [`HEAP_ARRAY_BITS-1:0] arr,
                           input logic [`HEAP_INDEX_BITS-1:0] idx,
                           input logic [`HEAP_DATA_BITS-1:0]  data);
    heapErr_t  expErr;
    heapWord_t expWord;
    int        cycles;
    applyModel(op, arr, idx, data, expErr, expWord);
    @(posedge clock);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbAdr  <= {op, arr, idx};
    wbDatW <= data;
    cycles = 0;
    @(negedge clock);                                        // Accepted at the next rising edge
    while (!(wbAck || wbErr) && cycles < 10) begin
      @(negedge clock);
      cycles++;
    end
    checkLatency(cycles);
    checkErr(errorCode, wbAck, wbErr, expErr);
    checkWord(wbDatR, expWord, op);
    @(posedge clock);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
  endtask

  task automatic randomRequest();
    logic [31:0]                 rnd;
    logic [`HEAP_OP_BITS-1:0]    op;
    logic [`HEAP_ARRAY_BITS-1:0] arr;
    logic [`HEAP_INDEX_BITS-1:0] idx;
    int                          pick;
    int                          tries;
    pick = nextRandom() % 12;
    op   = legalOps[pick];
    rnd  = nextRandom();
    if (rnd % 10 == 0) op = rnd[12:8];                       // May be undefined
    rnd = nextRandom();
    arr = rnd[`HEAP_ARRAY_BITS-1:0];
    tries = 0;
    if (nextRandom() % 10 != 0) begin
      while (!modelFlags[arr] && tries < 8) begin            // Prefer live arrays
        rnd = nextRandom();
        arr = rnd[`HEAP_ARRAY_BITS-1:0];
        tries++;
      end
    end
    rnd = nextRandom();
    idx = rnd[`HEAP_INDEX_BITS-1:0];
    if (modelSizes[arr] > 0 && rnd[31:8] % 10 != 0) begin
      pick = rnd[15:8] % modelSizes[arr];
      idx  = pick[`HEAP_INDEX_BITS-1:0];
    end
    rnd = nextRandom();
    doRequest(op, arr, idx, rnd[`HEAP_DATA_BITS-1:0]);
  endtask

  task automatic finishTest(input string name);
    $display("Test %s finished with %0d failed checks", name, failCount - testStart);
    testStart = failCount;
  endtask

  //----------------------------
  // Test sequence
  //----------------------------
  initial begin
    logic [31:0] rnd;
    logic [3:0]  arr;
    seed      = 32'h6dab_95eb;
    passCount = 0;
    failCount = 0;
    testStart = 0;
    reset     = 1'b1;
    wbCyc     = 1'b0;
    wbStb     = 1'b0;
    wbAdr     = '0;
    wbDatW    = '0;
    resetModel();
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    for (int h = 0; h < `HEAP_ARRAYS; h++) doRequest(opAlloc, '0, '0, '0);
    doRequest(opAlloc, '0, '0, '0);                          // One too many
    doRequest(opFree, 4'd5, '0, '0);
    doRequest(opFree, 4'd9, '0, '0);
    doRequest(opAlloc, '0, '0, '0);                          // Last freed comes back first
    doRequest(opAlloc, '0, '0, '0);
    doRequest(opFree, 4'd9, '0, '0);
    doRequest(opFree, 4'd9, '0, '0);                         // Second free
    doRequest(opRead, 4'd9, '0, '0);
    doRequest(opAlloc, '0, '0, '0);
    doRequest(5'd0, 4'd1, '0, '0);
    doRequest(5'd31, 4'd1, '0, '0);
    finishTest("allocation");

    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      arr = a[3:0];
      rnd = nextRandom();
      doRequest(opWrite, arr, arr[2:0], rnd[15:0]);          // Grows the size past the gap
      doRequest(opSize, arr, '0, '0);
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
        rnd = nextRandom();
        doRequest(opWrite, arr, i[2:0], rnd[15:0]);
      end
    end
    finishTest("writeSize");

    repeat (`HEAP_ARRAY_LENGTH) doRequest(opPop, 4'd2, '0, '0);
    doRequest(opPop, 4'd2, '0, '0);
    for (int i = 0; i <= `HEAP_ARRAY_LENGTH; i++) begin
      rnd = nextRandom();
      doRequest(opPush, 4'd2, '0, rnd[15:0]);                // Last one finds the array full
    end
    repeat (3) doRequest(opPop, 4'd2, '0, '0);
    doRequest(opRead, 4'd2, 3'd6, '0);
    doRequest(opRead, 4'd2, 3'd4, '0);
    finishTest("pushPop");

    for (int k = 7; k < 12; k++) begin
      rnd = nextRandom();
      doRequest(legalOps[k], 4'd4, rnd[18:16], rnd[15:0]);
      doRequest(opRead, 4'd4, rnd[18:16], '0);
    end
    finishTest("arithmetic");

    repeat (numRandom) randomRequest();
    finishTest("random");

    $display("Checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
+incdir+sim
verilog/heapPkg.sv
verilog/arrayAllocator.sv
verilog/sizeTable.sv
verilog/elementStore.sv
verilog/heapSequencer.sv
verilog/heapTop.sv
sim/heapTb.sv

/* verilog/arrayAllocator.sv */
//----------------------------
// Hands out array handles. Freed handles go on a LIFO and are
// reused before untouched arrays. Keeps one allocated flag per array.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module arrayAllocator (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        allocGrant,
  input  logic                        freeRelease,
  input  logic [`HEAP_ARRAY_BITS-1:0] handle,
  output logic                        allocated,
  output logic [`HEAP_ARRAY_BITS-1:0] grantHandle,
  output logic                        outOfMemory
);

  logic [`HEAP_ARRAY_BITS-1:0] freeStack [`HEAP_ARRAYS];       // Freed handles
  logic [`HEAP_ARRAY_BITS:0]   stackDepth;                    // 0 to 16
  logic [`HEAP_ARRAY_BITS:0]   newCount;                      // Arrays ever handed out
  logic [`HEAP_ARRAYS-1:0]     flags;
  logic [`HEAP_ARRAY_BITS-1:0] topSlot;

  assign topSlot     = stackDepth[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign grantHandle = (stackDepth != '0) ? freeStack[topSlot]
                                          : newCount[`HEAP_ARRAY_BITS-1:0];
  assign outOfMemory = (stackDepth == '0) && (newCount == `HEAP_ARRAYS);
  assign allocated   = flags[handle];

  always_ff @(posedge clock) begin
    if (reset) begin
      stackDepth <= '0;
      newCount   <= '0;
      flags      <= '0;
    end else if (allocGrant) begin
      flags[grantHandle] <= 1'b1;
      if (stackDepth != '0) stackDepth <= stackDepth - 1'b1;  // Reuse before new
      else newCount <= newCount + 1'b1;
    end else if (freeRelease) begin
      flags[handle] <= 1'b0;
      stackDepth    <= stackDepth + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (freeRelease && !allocGrant) begin
      freeStack[stackDepth[`HEAP_ARRAY_BITS-1:0]] <= handle;
    end
  end

  // Only live arrays can be freed, so the stack never overflows
  assert property (@(posedge clock) disable iff (reset) stackDepth <= `HEAP_ARRAYS);

endmodule

/* verilog/elementStore.sv */
//----------------------------
// Element memory of all arrays. Writes, pushes and read-modify-write
// operations commit on the clock edge; reads are combinational.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module elementStore import heapPkg::*; (
  input  logic                        clock,
  input  logic                        storeValid,
  input  heapOp_t                     storeOp,
  input  logic [`HEAP_ARRAY_BITS-1:0] handle,
  input  logic [`HEAP_INDEX_BITS-1:0] storeIndex,
  input  logic [`HEAP_DATA_BITS-1:0]  wbDatW,
  output logic [`HEAP_DATA_BITS-1:0]  storeData
);

  logic [`HEAP_DATA_BITS-1:0] memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  logic [`HEAP_DATA_BITS-1:0] stored;
  logic [`HEAP_DATA_BITS-1:0] newValue;
  logic                       isArith;

  assign stored = memory[handle][storeIndex];

  //----------------------------
  // Operation select
  //----------------------------
  always_comb begin
    isArith  = 1'b1;
    newValue = wbDatW;                                        // Plain store for write and push
    case (storeOp)
      opAdd:      newValue = stored + wbDatW;                 // Wraps modulo 2^16
      opSubtract: newValue = stored - wbDatW;
      opOr:       newValue = stored | wbDatW;
      opXor:      newValue = stored ^ wbDatW;
      opAnd:      newValue = stored & wbDatW;
      default:    isArith = 1'b0;
    endcase
  end

  assign storeData = isArith ? newValue : stored;

  always_ff @(posedge clock) begin
    if (storeValid) memory[handle][storeIndex] <= newValue;
  end

  // Only storing opcodes commit, at a known index
  assert property (@(posedge clock)
    storeValid |-> (!$isunknown(storeIndex) &&
                    (storeOp inside {opWrite, opPush, opAdd, opSubtract, opOr, opXor, opAnd})));

endmodule

/* verilog/heapPkg.sv */
//----------------------------
// Opcode and error encodings plus the response word of the heap.
// Imported by the RTL and the testbench.
//----------------------------
`include "heap_defs.svh"

package heapPkg;

  // Opcodes as carried in the opcode field of the address
  typedef enum logic [`HEAP_OP_BITS-1:0] {
    opWrite    = 5'd2,                                        // Store, growing the size
    opRead     = 5'd3,
    opSize     = 5'd4,
    opPush     = 5'd14,
    opPop      = 5'd15,
    opAlloc    = 5'd18,                                       // Returns a handle
    opFree     = 5'd19,
    opAdd      = 5'd20,                                       // Arithmetic returns the new value
    opSubtract = 5'd22,
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                          // Never allocated or freed
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory,
    errBadOp
  } heapErr_t;

  //----------------------------
  // Response word
  //----------------------------
  typedef union packed {
    logic [`HEAP_DATA_BITS-1:0] element;                      // Read, pop, arithmetic
    struct packed {
      logic [`HEAP_DATA_BITS-`HEAP_SIZE_BITS-1:0] pad;         // Always zero
      logic [`HEAP_SIZE_BITS-1:0]                 count;       // Handle or size
    } counted;
  } heapWord_t;

endpackage

/* verilog/heapSequencer.sv */
//----------------------------
// Wishbone slave FSM of the heap. Takes one request at a time,
// validates it, steers the allocator, size table and element store,
// then answers with wbAck or wbErr three cycles after acceptance.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module heapSequencer import heapPkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        wbCyc,
  input  logic                        wbStb,
  input  logic [`HEAP_ADR_BITS-1:0]   wbAdr,
  input  logic [`HEAP_DATA_BITS-1:0]  wbDatW,
  output heapWord_t                   wbDatR,
  output logic                        wbAck,
  output logic                        wbErr,
  output heapErr_t                    errorCode,
  output logic                        allocGrant,
  output logic                        freeRelease,
  output logic [`HEAP_ARRAY_BITS-1:0] handle,
  input  logic                        allocated,
  input  logic [`HEAP_ARRAY_BITS-1:0] grantHandle,
  input  logic                        outOfMemory,
  output logic [1:0]                  sizeOp,
  output logic [`HEAP_INDEX_BITS-1:0] sizeIndex,
  input  logic [`HEAP_SIZE_BITS-1:0]  currentSize,
  output heapOp_t                     storeOp,
  output logic [`HEAP_INDEX_BITS-1:0] storeIndex,
  output logic                        storeValid,
  input  logic [`HEAP_DATA_BITS-1:0]  storeData
);

  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] CHECK   = 2'd1;
  localparam logic [1:0] EXEC    = 2'd2;
  localparam logic [1:0] RESPOND = 2'd3;

  logic [1:0]                  state;
  heapOp_t                     opReg;                         // Registered request fields
  logic [`HEAP_ARRAY_BITS-1:0] arrayReg;
  logic [`HEAP_INDEX_BITS-1:0] indexReg;
  heapErr_t                    chkNext;
  heapErr_t                    chkErr;                        // Verdict from CHECK
  heapWord_t                   respWord;
  heapWord_t                   datReg;
  logic                        issue;                         // Approved request in EXEC
  logic [`HEAP_INDEX_BITS-1:0] opIndex;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= IDLE;
      errorCode <= errNone;
    end else begin
      case (state)
        IDLE:    if (wbCyc && wbStb) state <= CHECK;
        CHECK:   state <= EXEC;
        EXEC: begin
          state     <= RESPOND;
          errorCode <= chkErr;                                // Held until the next response
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE) begin
      opReg    <= heapOp_t'(wbAdr[`HEAP_OP_LSB +: `HEAP_OP_BITS]);
      arrayReg <= wbAdr[`HEAP_ARRAY_LSB +: `HEAP_ARRAY_BITS];
      indexReg <= wbAdr[`HEAP_INDEX_BITS-1:0];
    end
    if (state == CHECK) chkErr <= chkNext;
    if (state == EXEC) datReg <= (chkErr == errNone) ? respWord : '0;
  end

  //----------------------------
  // Request checks
  //----------------------------
  always_comb begin
    chkNext = errNone;
    case (opReg)
      opAlloc: if (outOfMemory) chkNext = errOutOfMemory;
      opWrite, opSize, opFree: if (!allocated) chkNext = errNotAllocated;
      opRead, opAdd, opSubtract, opOr, opXor, opAnd: begin
        if (!allocated) chkNext = errNotAllocated;
        else if ({1'b0, indexReg} >= currentSize) chkNext = errOutOfBounds;
      end
      opPush: begin
        if (!allocated) chkNext = errNotAllocated;
        else if (currentSize == `HEAP_ARRAY_LENGTH) chkNext = errFull;
      end
      opPop: begin
        if (!allocated) chkNext = errNotAllocated;
        else if (currentSize == '0) chkNext = errEmpty;
      end
      default: chkNext = errBadOp;
    endcase
  end

  // Push lands at the end, pop takes the last element
  always_comb begin
    case (opReg)
      opPush:  opIndex = currentSize[`HEAP_INDEX_BITS-1:0];
      opPop:   opIndex = currentSize[`HEAP_INDEX_BITS-1:0] - 1'b1;
      default: opIndex = indexReg;
    endcase
  end

  assign issue       = (state == EXEC) && (chkErr == errNone);
  assign handle      = (opReg == opAlloc) ? grantHandle : arrayReg;
  assign allocGrant  = issue && (opReg == opAlloc);
  assign freeRelease = issue && (opReg == opFree);
  assign storeOp     = opReg;
  assign storeIndex  = opIndex;
  assign sizeIndex   = opIndex;
  assign storeValid  = issue && (opReg inside {opWrite, opPush, opAdd, opSubtract,
                                               opOr, opXor, opAnd});

  // A push grows to size plus one through the same path as a write
  always_comb begin
    sizeOp = `HEAP_SIZE_HOLD;
    if (issue) begin
      case (opReg)
        opAlloc:        sizeOp = `HEAP_SIZE_CLEAR;
        opWrite, opPush: sizeOp = `HEAP_SIZE_GROW;
        opPop:          sizeOp = `HEAP_SIZE_SHRINK;
        default:        sizeOp = `HEAP_SIZE_HOLD;
      endcase
    end
  end

  always_comb begin
    respWord = '0;
    case (opReg)
      opAlloc: respWord.counted.count = grantHandle;
      opSize:  respWord.counted.count = currentSize;
      opRead, opPop, opAdd, opSubtract, opOr, opXor, opAnd:
        respWord.element = storeData;                         // Updated value for arithmetic
      default: respWord = '0;
    endcase
  end

  assign wbAck  = (state == RESPOND) && (chkErr == errNone);
  assign wbErr  = (state == RESPOND) && (chkErr != errNone);
  assign wbDatR = datReg;

  //----------------------------
  // Bus checks
  //----------------------------
  assert property (@(posedge clock) disable iff (reset) !(wbAck && wbErr));
  assert property (@(posedge clock) disable iff (reset) (wbAck || wbErr) |-> wbCyc);
  // Master keeps address and operand steady while a request is in flight
  assert property (@(posedge clock) disable iff (reset)
    (state != IDLE && state != RESPOND) |=> ($stable(wbAdr) && $stable(wbDatW)));

endmodule

/* verilog/heapTop.sv */
//----------------------------
// Array heap with a Wishbone classic slave port.
// Opcode, handle and index travel in the address.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module heapTop import heapPkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       wbCyc,
  input  logic                       wbStb,
  input  logic [`HEAP_ADR_BITS-1:0]  wbAdr,
  input  logic [`HEAP_DATA_BITS-1:0] wbDatW,
  output heapWord_t                  wbDatR,
  output logic                       wbAck,
  output logic                       wbErr,
  output heapErr_t                   errorCode
);

  logic                        allocGrant;
  logic                        freeRelease;
  logic [`HEAP_ARRAY_BITS-1:0] handle;                        // Array of the current request
  logic                        allocated;
  logic [`HEAP_ARRAY_BITS-1:0] grantHandle;
  logic                        outOfMemory;
  logic [1:0]                  sizeOp;
  logic [`HEAP_INDEX_BITS-1:0] sizeIndex;
  logic [`HEAP_SIZE_BITS-1:0]  currentSize;
  heapOp_t                     storeOp;
  logic [`HEAP_INDEX_BITS-1:0] storeIndex;
  logic                        storeValid;
  logic [`HEAP_DATA_BITS-1:0]  storeData;

  heapSequencer u_heapSequencer (
    .clock       (clock),
    .reset       (reset),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbAdr       (wbAdr),
    .wbDatW      (wbDatW),
    .wbDatR      (wbDatR),
    .wbAck       (wbAck),
    .wbErr       (wbErr),
    .errorCode   (errorCode),
    .allocGrant  (allocGrant),
    .freeRelease (freeRelease),
    .handle      (handle),
    .allocated   (allocated),
    .grantHandle (grantHandle),
    .outOfMemory (outOfMemory),
    .sizeOp      (sizeOp),
    .sizeIndex   (sizeIndex),
    .currentSize (currentSize),
    .storeOp     (storeOp),
    .storeIndex  (storeIndex),
    .storeValid  (storeValid),
    .storeData   (storeData)
  );

  arrayAllocator u_arrayAllocator (
    .clock       (clock),
    .reset       (reset),
    .allocGrant  (allocGrant),
    .freeRelease (freeRelease),
    .handle      (handle),
    .allocated   (allocated),
    .grantHandle (grantHandle),
    .outOfMemory (outOfMemory)
  );

  sizeTable u_sizeTable (
    .clock       (clock),
    .reset       (reset),
    .sizeOp      (sizeOp),
    .handle      (handle),
    .sizeIndex   (sizeIndex),
    .currentSize (currentSize)
  );

  elementStore u_elementStore (
    .clock       (clock),
    .storeValid  (storeValid),
    .storeOp     (storeOp),
    .handle      (handle),
    .storeIndex  (storeIndex),
    .wbDatW      (wbDatW),                                    // Operand straight from the bus
    .storeData   (storeData)
  );

endmodule

/* verilog/heap_defs.svh */
//----------------------------
// Geometry of the array heap and the layout of the Wishbone address.
// Include in every file that sizes a port or slices the address.
//----------------------------
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

//----------------------------
// Geometry
//----------------------------
`define HEAP_ARRAY_BITS   4                                   // Bits in an array handle
`define HEAP_ARRAYS       (1 << `HEAP_ARRAY_BITS)             // 16 arrays
`define HEAP_INDEX_BITS   3                                   // Bits in an element index
`define HEAP_ARRAY_LENGTH 8                                   // Elements per array
`define HEAP_SIZE_BITS    (`HEAP_INDEX_BITS + 1)              // Size can reach the full length
`define HEAP_DATA_BITS    16                                  // Element and bus width

//----------------------------
// Address fields, index at the bottom
//----------------------------
`define HEAP_OP_BITS      5
`define HEAP_ADR_BITS     (`HEAP_OP_BITS + `HEAP_ARRAY_BITS + `HEAP_INDEX_BITS)
`define HEAP_ARRAY_LSB    `HEAP_INDEX_BITS
`define HEAP_OP_LSB       (`HEAP_ARRAY_LSB + `HEAP_ARRAY_BITS)

// Size table commands
`define HEAP_SIZE_HOLD    2'd0                                // Leave sizes alone
`define HEAP_SIZE_CLEAR   2'd1                                // Empty a freshly granted array
`define HEAP_SIZE_GROW    2'd2                                // Raise to index plus one
`define HEAP_SIZE_SHRINK  2'd3                                // Drop by one on pop

`endif

/* verilog/sizeTable.sv */
//----------------------------
// Current size of every array. Cleared on allocation, grown by
// writes past the end and pushes, shrunk by pops.
//----------------------------
`timescale 1ns/10ps
`include "heap_defs.svh"

module sizeTable (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [1:0]                  sizeOp,
  input  logic [`HEAP_ARRAY_BITS-1:0] handle,
  input  logic [`HEAP_INDEX_BITS-1:0] sizeIndex,
  output logic [`HEAP_SIZE_BITS-1:0]  currentSize
);

  logic [`HEAP_SIZE_BITS-1:0] sizes [`HEAP_ARRAYS];
  logic [`HEAP_SIZE_BITS-1:0] growTo;

  assign currentSize = sizes[handle];
  assign growTo      = {1'b0, sizeIndex} + 1'b1;              // Index plus one

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      case (sizeOp)
        `HEAP_SIZE_CLEAR: sizes[handle] <= '0;
        `HEAP_SIZE_GROW: begin
          if (growTo > currentSize) sizes[handle] <= growTo;  // Writes inside keep the size
        end
        `HEAP_SIZE_SHRINK: sizes[handle] <= currentSize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule
